//--- csr_sub.f
+incdir+source
source/csr_pkg.sv
source/bfs_wb_bridge.sv
source/bfs_regs.sv
source/csr_unit.sv
source/csr_top.sv
bench/csr_tb.sv

//--- Bender.yml
package:
  name: csr_sub

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/csr_pkg.sv
      - source/bfs_wb_bridge.sv
      - source/bfs_regs.sv
      - source/csr_unit.sv
      - source/csr_top.sv

  - target: test
    include_dirs:
      - source
    files:
      - bench/csr_tb.sv

//--- bench/csr_tb.sv
// testbench for csr_top that stops at the first mismatch and never compares the MCYCLE low half
`timescale 1ns/1ps
`default_nettype none
`include "csr_cfg.svh"

module csr_tb import csr_pkg::*; ();

  localparam int CLK_PERIOD  = 100;
  localparam int DRIVE_DELAY = 10;
  localparam int ROW_CYCLES  = 20;

  // one table row with stimulus, expected error and optional fixed result
  typedef struct packed {
    csr_op_t    op;
    csr_addr_t  addr;
    xlen_t      op1;
    logic       rnd;
    logic [3:0] rets;
    logic       done;
    logic       l2;
    logic       fixed;
    xlen_t      exp_res;
    logic       err;
  } row_t;

  logic       clk;
  logic       rst;
  logic       rename_valid;
  csr_req_t   rename_req;
  logic       rob_ret_valid;
  logic       rob_ret_csr;
  logic       l2_req;
  logic       bfs_done;
  logic       csr_stall;
  logic       resp_valid;
  csr_resp_t  resp;
  logic       uart_tx_valid;
  logic [7:0] uart_tx_data;
  logic       bfs_start;
  bfs_cfg_t   bfs_cfg;

  row_t        rows[$];
  integer      seed = 37375;
  int unsigned n_rows = 0;

  // reference model
  logic [63:0] m_instret = '0;
  xlen_t       m_cycleh = '0;
  logic [7:0]  m_uart = '0;
  logic        m_busy = 1'b0;
  bfs_cfg_t    m_cfg = '0;
  int          tx_want = 0;
  int          tx_seen = 0;
  int          start_want = 0;
  int          start_seen = 0;

  csr_top dut (
    .clk           (clk),
    .rst           (rst),
    .rename_valid  (rename_valid),
    .rename_req    (rename_req),
    .rob_ret_valid (rob_ret_valid),
    .rob_ret_csr   (rob_ret_csr),
    .l2_req        (l2_req),
    .bfs_done      (bfs_done),
    .csr_stall     (csr_stall),
    .resp_valid    (resp_valid),
    .resp          (resp),
    .uart_tx_valid (uart_tx_valid),
    .uart_tx_data  (uart_tx_data),
    .bfs_start     (bfs_start),
    .bfs_cfg       (bfs_cfg)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic abort_run;
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic value_error(input string name, input logic [127:0] got,
                             input logic [127:0] want);
    $display("** Error: %s got 0x%0h expected 0x%0h", name, got, want);
    abort_run();
  endtask

  task automatic check_resp(input csr_resp_t got, input csr_resp_t want);
    if (got.error !== want.error) value_error("resp.error", got.error, want.error);
    if (got.ecause !== want.ecause) value_error("resp.ecause", got.ecause, want.ecause);
    if (got.robid !== want.robid) value_error("resp.robid", got.robid, want.robid);
    if (got.rd !== want.rd) value_error("resp.rd", got.rd, want.rd);
    // result of a failed access is undefined
    if (!want.error && got.result !== want.result) begin
      value_error("resp.result", got.result, want.result);
    end
  endtask

  task automatic check_cfg(input bfs_cfg_t got, input bfs_cfg_t want);
    if (got.root !== want.root) value_error("bfs_cfg.root", got.root, want.root);
    if (got.targ !== want.targ) value_error("bfs_cfg.targ", got.targ, want.targ);
    if (got.qbase !== want.qbase) value_error("bfs_cfg.qbase", got.qbase, want.qbase);
    if (got.qsize !== want.qsize) value_error("bfs_cfg.qsize", got.qsize, want.qsize);
  endtask

  task automatic check_uart(input logic [7:0] got, input logic [7:0] want);
    if (got !== want) value_error("uart_tx_data", got, want);
  endtask

  task automatic check_stall(input logic got, input logic want);
    if (got !== want) value_error("csr_stall", got, want);
  endtask

  function automatic xlen_t model_read(input csr_addr_t a);
    xlen_t v;
    v = '0;
    if (a[11:4] == `CSR_BFS_BASE) begin
      case (a[3:0])
        `BFS_STAT:  v = {31'd0, m_busy};
        `BFS_ROOT:  v = m_cfg.root;
        `BFS_TARG:  v = m_cfg.targ;
        `BFS_QBASE: v = m_cfg.qbase;
        `BFS_QSIZE: v = m_cfg.qsize;
        default:    v = '0;
      endcase
    end else begin
      case (a)
        `CSR_MCYCLEH:   v = m_cycleh;
        `CSR_MINSTRET:  v = m_instret[31:0];
        `CSR_MINSTRETH: v = m_instret[63:32];
        `CSR_MUARTSTAT: v = `UART_STAT_IDLE;
        `CSR_MUARTTX:   v = {24'd0, m_uart};
        default:        v = '0;
      endcase
    end
    return v;
  endfunction

  task automatic model_write(input csr_op_t op, input csr_addr_t a, input xlen_t op1,
                             input xlen_t old);
    xlen_t nv;
    case (op)
      CSR_SET:   nv = old | op1;
      CSR_CLEAR: nv = old & ~op1;
      default:   nv = op1;
    endcase
    if (a[11:4] == `CSR_BFS_BASE) begin
      case (a[3:0])
        `BFS_STAT: begin
          if (nv[0]) begin
            m_busy = 1'b1;
            start_want++;
          end
        end
        `BFS_ROOT:  m_cfg.root = nv;
        `BFS_TARG:  m_cfg.targ = nv;
        `BFS_QBASE: m_cfg.qbase = nv;
        `BFS_QSIZE: m_cfg.qsize = nv;
        default: ;
      endcase
    end else begin
      case (a)
        `CSR_MCYCLEH:   m_cycleh = nv;
        `CSR_MINSTRET:  m_instret[31:0] = nv;
        `CSR_MINSTRETH: m_instret[63:32] = nv;
        `CSR_MUARTTX: begin
          m_uart = nv[7:0];
          tx_want++;
        end
        default: ;
      endcase
    end
  endtask

  task automatic add_row(input csr_op_t op, input csr_addr_t addr, input xlen_t op1,
                         input logic rnd, input logic [3:0] rets, input logic done,
                         input logic l2, input logic fixed, input xlen_t exp_res,
                         input logic err);
    row_t r;
    r.op      = op;
    r.addr    = addr;
    r.op1     = op1;
    r.rnd     = rnd;
    r.rets    = rets;
    r.done    = done;
    r.l2      = l2;
    r.fixed   = fixed;
    r.exp_res = exp_res;
    r.err     = err;
    rows.push_back(r);
  endtask

  // columns are op, addr, op1, rnd, rets, done, l2, fixed, exp_res and err
  task automatic build_table;
    add_row(CSR_READ,  `CSR_MINSTRETH, 32'h0, 1, 0, 0, 0, 1, 32'h0, 0);
    add_row(CSR_WRITE, `CSR_MINSTRETH, 32'h0, 1, 0, 0, 0, 0, 32'h0, 0);
    add_row(CSR_SET,   `CSR_MINSTRETH, 32'h0000_F0F0, 0, 0, 0, 0, 0, 32'h0, 0);
    add_row(CSR_CLEAR, `CSR_MINSTRETH, 32'h0, 1, 0, 0, 0, 0, 32'h0, 0);
    add_row(CSR_READ,  `CSR_MINSTRETH, 32'h0, 0, 0, 0, 0, 0, 32'h0, 0);
    add_row(CSR_WRITE, `CSR_MINSTRET, 32'h0000_1000, 0, 0, 0, 0, 0, 32'h0, 0);
    add_row(CSR_READ,  `CSR_MINSTRET, 32'h0, 0, 3, 0, 0, 0, 32'h0, 0);
    add_row(CSR_SET,   `CSR_MINSTRET, 32'h00FF_0000, 0, 2, 0, 0, 0, 32'h0, 0);
    add_row(CSR_CLEAR, `CSR_MINSTRET, 32'h0000_0001, 0, 0, 0, 0, 0, 32'h0, 0);
    add_row(CSR_READ,  `CSR_MINSTRET, 32'h0, 0, 1, 0, 0, 0, 32'h0, 0);
    // high half of the cycle counter only
    add_row(CSR_WRITE, `CSR_MCYCLEH, 32'h0, 1, 0, 0, 0, 0, 32'h0, 0);
    add_row(CSR_READ,  `CSR_MCYCLEH, 32'h0, 0, 0, 0, 0, 0, 32'h0, 0);
    add_row(CSR_WRITE, `CSR_MCYCLEH, 32'h1234_5678, 0, 0, 0, 0, 0, 32'h0, 0);
    add_row(CSR_READ,  `CSR_MCYCLEH, 32'h0, 0, 0, 0, 0, 0, 32'h0, 0);
    // uart
    add_row(CSR_WRITE, `CSR_MUARTTX, 32'h0000_01A5, 0, 0, 0, 0, 0, 32'h0, 0);
    add_row(CSR_READ,  `CSR_MUARTTX, 32'h0, 0, 0, 0, 0, 0, 32'h0, 0);
    add_row(CSR_READ,  `CSR_MUARTSTAT, 32'h0, 0, 0, 0, 0, 1, 32'h5, 0);
    add_row(CSR_WRITE, `CSR_MUARTTX, 32'h0, 1, 0, 0, 0, 0, 32'h0, 0);
    // accelerator config through the wishbone bank
    add_row(CSR_WRITE, {`CSR_BFS_BASE, `BFS_ROOT}, 32'h0, 1, 0, 0, 0, 0, 32'h0, 0);
    add_row(CSR_WRITE, {`CSR_BFS_BASE, `BFS_TARG}, 32'h0, 1, 0, 0, 0, 0, 32'h0, 0);
    add_row(CSR_WRITE, {`CSR_BFS_BASE, `BFS_QBASE}, 32'h0, 1, 0, 0, 0, 0, 32'h0, 0);
    add_row(CSR_WRITE, {`CSR_BFS_BASE, `BFS_QSIZE}, 32'h0, 1, 0, 0, 0, 0, 32'h0, 0);
    add_row(CSR_READ,  {`CSR_BFS_BASE, `BFS_ROOT}, 32'h0, 0, 0, 0, 0, 0, 32'h0, 0);
    add_row(CSR_READ,  {`CSR_BFS_BASE, `BFS_TARG}, 32'h0, 0, 0, 0, 0, 0, 32'h0, 0);
    add_row(CSR_READ,  {`CSR_BFS_BASE, `BFS_QBASE}, 32'h0, 0, 0, 0, 0, 0, 32'h0, 0);
    add_row(CSR_READ,  {`CSR_BFS_BASE, `BFS_QSIZE}, 32'h0, 0, 0, 0, 0, 0, 32'h0, 0);
    add_row(CSR_READ,  {`CSR_BFS_BASE, 4'h7}, 32'h0, 0, 0, 0, 0, 0, 32'h0, 1);
    add_row(CSR_WRITE, {`CSR_BFS_BASE, 4'h7}, 32'h0, 1, 0, 0, 0, 0, 32'h0, 1);
    add_row(CSR_SET,   {`CSR_BFS_BASE, `BFS_TARG}, 32'h1, 0, 0, 0, 0, 0, 32'h0, 1);
    // start and done
    add_row(CSR_READ,  {`CSR_BFS_BASE, `BFS_STAT}, 32'h0, 0, 0, 0, 0, 0, 32'h0, 0);
    add_row(CSR_WRITE, {`CSR_BFS_BASE, `BFS_STAT}, 32'h1, 0, 0, 0, 0, 0, 32'h0, 0);
    add_row(CSR_READ,  {`CSR_BFS_BASE, `BFS_STAT}, 32'h0, 0, 0, 0, 0, 0, 32'h0, 0);
    add_row(CSR_READ,  {`CSR_BFS_BASE, `BFS_STAT}, 32'h0, 0, 0, 1, 0, 0, 32'h0, 0);
    // illegal accesses and the l2 line
    add_row(CSR_READ,  12'h300, 32'h0, 0, 0, 0, 0, 0, 32'h0, 1);
    add_row(CSR_WRITE, `CSR_MUARTSTAT, 32'h0, 1, 0, 0, 0, 0, 32'h0, 1);
    add_row(CSR_READ,  `CSR_ML2STAT, 32'h0, 0, 0, 0, 1, 1, 32'h1, 0);
    add_row(CSR_WRITE, `CSR_ML2STAT, 32'h1, 0, 0, 0, 1, 1, 32'h0, 0);
    add_row(CSR_READ,  `CSR_MINSTRETH, 32'h0, 0, 0, 0, 0, 0, 32'h0, 0);
  endtask

  task automatic run_row(input int idx);
    row_t      r;
    xlen_t     op1;
    xlen_t     old;
    csr_resp_t want;
    logic      bus_row;
    int        want_cycles;
    int        cycles;
    r   = rows[idx];
    op1 = r.rnd ? xlen_t'($random(seed)) : r.op1;
    if (r.done) begin
      @(posedge clk);
      #DRIVE_DELAY bfs_done = 1'b1;
      @(posedge clk);
      #DRIVE_DELAY bfs_done = 1'b0;
      m_busy = 1'b0;
    end
    if (r.rets != 0) begin
      @(posedge clk);
      #DRIVE_DELAY rob_ret_valid = 1'b1;
      repeat (r.rets) @(posedge clk);
      #DRIVE_DELAY rob_ret_valid = 1'b0;
      m_instret = m_instret + r.rets;
    end
    @(posedge clk);
    #DRIVE_DELAY;
    rename_valid     = 1'b1;
    rename_req.op    = r.op;
    rename_req.robid = robid_t'(idx);
    rename_req.rd    = preg_t'(idx);
    rename_req.op1   = op1;
    rename_req.addr  = r.addr;
    l2_req           = r.l2;
    // hold the request until the stage takes it
    do @(negedge clk); while (csr_stall);
    @(posedge clk);
    #DRIVE_DELAY rename_valid = 1'b0;
    // bus accesses and held l2 writes answer on the second cycle
    bus_row     = (r.addr[11:4] == `CSR_BFS_BASE) && (r.op == CSR_READ || r.op == CSR_WRITE);
    want_cycles = bus_row ? 2 : 1;
    if (r.l2 && r.op != CSR_READ && r.addr == `CSR_ML2STAT) begin
      repeat (4) begin
        @(negedge clk);
        if (resp_valid) begin
          $display("write to ML2STAT was answered while l2_req was still high");
          abort_run();
        end
      end
      @(posedge clk);
      #DRIVE_DELAY l2_req = 1'b0;
      want_cycles = 2;
    end
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
      check_stall(csr_stall, cycles < want_cycles);
    end while (cycles < want_cycles);
    if (resp_valid !== 1'b1) value_error("resp_valid", resp_valid, 1'b1);
    old = r.fixed ? r.exp_res : model_read(r.addr);
    want.error  = r.err;
    want.ecause = r.err ? `ECAUSE_ILLEGAL : 5'd0;
    want.robid  = robid_t'(idx);
    want.rd     = preg_t'(idx);
    want.result = old;
    check_resp(resp, want);
    if (!r.err && r.op != CSR_READ) model_write(r.op, r.addr, op1, old);
    // uart pulse lands one cycle after the result
    repeat (2) @(negedge clk);
    if (tx_seen != tx_want) begin
      $display("row %0d saw %0d uart_tx_valid pulses, model has %0d", idx, tx_seen, tx_want);
      abort_run();
    end
    if (start_seen != start_want) begin
      $display("row %0d saw %0d bfs_start pulses, model has %0d", idx, start_seen, start_want);
      abort_run();
    end
    check_cfg(bfs_cfg, m_cfg);
  endtask

  always @(negedge clk) begin
    if (uart_tx_valid === 1'b1) begin
      tx_seen++;
      check_uart(uart_tx_data, m_uart);
    end
    if (bfs_start === 1'b1) begin
      start_seen++;
    end
  end

  initial begin
    wait (n_rows != 0);
    #(n_rows * ROW_CYCLES * CLK_PERIOD + 10 * CLK_PERIOD);
    $display("timeout, a CSR result never arrived within %0d cycles", n_rows * ROW_CYCLES);
    abort_run();
  end

  initial begin
    rst           = 1'b1;
    rename_valid  = 1'b0;
    rename_req    = '0;
    rob_ret_valid = 1'b0;
    rob_ret_csr   = 1'b0;
    l2_req        = 1'b0;
    bfs_done      = 1'b0;
    build_table();
    n_rows = rows.size();
    repeat (5) @(posedge clk);
    #DRIVE_DELAY rst = 1'b0;
    for (int i = 0; i < n_rows; i++) begin
      run_row(i);
    end
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

//--- source/csr_top.sv
// CSR block top; the BFS engine is outside, seen only through start, config and done
`timescale 1ns/1ps
`default_nettype none

module csr_top import csr_pkg::*; (
  input  wire             clk,
  input  wire             rst,
  input  wire             rename_valid,
  input  wire csr_req_t   rename_req,
  input  wire             rob_ret_valid,
  input  wire             rob_ret_csr,
  input  wire             l2_req,
  input  wire             bfs_done,
  output logic            csr_stall,
  output logic            resp_valid,
  output csr_resp_t       resp,
  output logic            uart_tx_valid,
  output logic [7:0]      uart_tx_data,
  output logic            bfs_start,
  output bfs_cfg_t        bfs_cfg
);

  logic     bfs_valid;
  bfs_req_t bfs_req;
  logic     bfs_rsp_valid;
  bfs_rsp_t bfs_rsp;
  wb_m2s_t  wb_m2s;
  wb_s2m_t  wb_s2m;

  csr_unit u_csr_unit (
    .clk           (clk),
    .rst           (rst),
    .rename_valid  (rename_valid),
    .rename_req    (rename_req),
    .rob_ret_valid (rob_ret_valid),
    .rob_ret_csr   (rob_ret_csr),
    .l2_req        (l2_req),
    .bfs_rsp_valid (bfs_rsp_valid),
    .bfs_rsp       (bfs_rsp),
    .csr_stall     (csr_stall),
    .resp_valid    (resp_valid),
    .resp          (resp),
    .uart_tx_valid (uart_tx_valid),
    .uart_tx_data  (uart_tx_data),
    .bfs_valid     (bfs_valid),
    .bfs_req       (bfs_req)
  );

  bfs_wb_bridge u_bridge (
    .clk           (clk),
    .rst           (rst),
    .bfs_valid     (bfs_valid),
    .bfs_req       (bfs_req),
    .wb_in         (wb_s2m),
    .wb_out        (wb_m2s),
    .bfs_rsp_valid (bfs_rsp_valid),
    .bfs_rsp       (bfs_rsp)
  );

  bfs_regs u_bfs_regs (
    .clk       (clk),
    .rst       (rst),
    .wb_in     (wb_m2s),
    .bfs_done  (bfs_done),
    .wb_out    (wb_s2m),
    .bfs_start (bfs_start),
    .bfs_cfg   (bfs_cfg)
  );

endmodule

`default_nettype wire

//--- source/csr_unit.sv
// one-entry CSR stage; no traps or flush, BFS set/clear unsupported, writeback never stalls
`timescale 1ns/1ps
`default_nettype none
`include "csr_cfg.svh"

module csr_unit import csr_pkg::*; (
  input  wire             clk,
  input  wire             rst,
  input  wire             rename_valid,
  input  wire csr_req_t   rename_req,
  input  wire             rob_ret_valid,
  input  wire             rob_ret_csr,
  input  wire             l2_req,
  input  wire             bfs_rsp_valid,
  input  wire bfs_rsp_t   bfs_rsp,
  output logic            csr_stall,
  output logic            resp_valid,
  output csr_resp_t       resp,
  output logic            uart_tx_valid,
  output logic [7:0]      uart_tx_data,
  output logic            bfs_valid,
  output bfs_req_t        bfs_req
);

  logic        valid_q;
  csr_req_t    stage_q;

  logic        sel_mcycle;
  logic        sel_mcycleh;
  logic        sel_minstret;
  logic        sel_minstreth;
  logic        sel_muartstat;
  logic        sel_muarttx;
  logic        sel_bfs;
  logic        sel_ml2stat;
  logic        sel_none;

  logic [63:0] cycle_q;
  logic [63:0] cycle_d;
  logic [63:0] instret_q;
  logic [63:0] instret_d;
  logic [7:0]  uart_q;

  xlen_t       old_val;
  xlen_t       wdata;
  logic        wen;
  logic        ro;
  logic        bus_op;
  logic        bfs_pend_q;
  logic        l2_stall;
  logic        l2_hold_q;
  logic        err;
  logic        do_write;
  logic        inc_instret;

  // stage register, held while stalled
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (!csr_stall) begin
      valid_q <= rename_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (!csr_stall && rename_valid) begin
      stage_q <= rename_req;
    end
  end

  // address decode
  always_comb begin
    sel_mcycle    = 1'b0;
    sel_mcycleh   = 1'b0;
    sel_minstret  = 1'b0;
    sel_minstreth = 1'b0;
    sel_muartstat = 1'b0;
    sel_muarttx   = 1'b0;
    sel_ml2stat   = 1'b0;
    sel_bfs       = (stage_q.addr[11:4] == `CSR_BFS_BASE);
    case (stage_q.addr)
      `CSR_MCYCLE:    sel_mcycle    = 1'b1;
      `CSR_MCYCLEH:   sel_mcycleh   = 1'b1;
      `CSR_MINSTRET:  sel_minstret  = 1'b1;
      `CSR_MINSTRETH: sel_minstreth = 1'b1;
      `CSR_MUARTSTAT: sel_muartstat = 1'b1;
      `CSR_MUARTTX:   sel_muarttx   = 1'b1;
      `CSR_ML2STAT:   sel_ml2stat   = 1'b1;
      default: ;
    endcase
    sel_none = ~(sel_mcycle | sel_mcycleh | sel_minstret | sel_minstreth |
                 sel_muartstat | sel_muarttx | sel_bfs | sel_ml2stat);
  end

  // read mux, old value is what the instruction returns
  always_comb begin
    case (1'b1)
      sel_mcycle:    old_val = cycle_q[31:0];
      sel_mcycleh:   old_val = cycle_q[63:32];
      sel_minstret:  old_val = instret_q[31:0];
      sel_minstreth: old_val = instret_q[63:32];
      sel_muartstat: old_val = `UART_STAT_IDLE;
      sel_muarttx:   old_val = {24'd0, uart_q};
      sel_bfs:       old_val = bfs_rsp.rdata;
      sel_ml2stat:   old_val = {31'd0, l2_req};
      default:       old_val = '0;
    endcase
  end

  always_comb begin
    wen = valid_q & (stage_q.op != CSR_READ);
    case (stage_q.op)
      CSR_WRITE: wdata = stage_q.op1;
      CSR_SET:   wdata = old_val | stage_q.op1;
      CSR_CLEAR: wdata = old_val & ~stage_q.op1;
      default:   wdata = old_val;
    endcase
  end

  // top two address bits set means read-only
  assign ro = &stage_q.addr[11:10];

  // only plain reads and writes go out on the bus
  assign bus_op    = (stage_q.op == CSR_READ) || (stage_q.op == CSR_WRITE);
  assign bfs_valid = valid_q & sel_bfs & bus_op & ~bfs_pend_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      bfs_pend_q <= 1'b0;
    end else begin
      bfs_pend_q <= bfs_valid;
    end
  end

  always_comb begin
    bfs_req.wen   = (stage_q.op == CSR_WRITE);
    bfs_req.addr  = stage_q.addr[3:0];
    bfs_req.wdata = stage_q.op1;
  end

  // l2 write waits for the request line to drop
  assign l2_stall = wen & sel_ml2stat & l2_req;

  always_ff @(posedge clk) begin
    if (rst || !l2_req) begin
      l2_hold_q <= 1'b0;
    end else if (wen && sel_ml2stat) begin
      l2_hold_q <= 1'b1;
    end
  end

  assign csr_stall = bfs_valid | l2_stall | l2_hold_q;

  assign err = sel_none | (wen & ro) | (valid_q & sel_bfs & ~bus_op) |
               (bfs_pend_q & (~bfs_rsp_valid | bfs_rsp.error));

  assign resp_valid = valid_q & ~csr_stall;
  assign do_write   = resp_valid & wen & ~err;

  always_comb begin
    resp.error  = err;
    resp.ecause = err ? `ECAUSE_ILLEGAL : 5'd0;
    resp.robid  = stage_q.robid;
    resp.rd     = stage_q.rd;
    resp.result = old_val;
  end

  // a CSR write to minstret retires without counting itself
  assign inc_instret = rob_ret_valid & ~(rob_ret_csr & valid_q & sel_minstret);

  always_comb begin
    cycle_d   = cycle_q + 64'd1;
    instret_d = instret_q + {63'd0, inc_instret};
    if (do_write) begin
      if (sel_mcycle) cycle_d[31:0] = wdata;
      if (sel_mcycleh) cycle_d[63:32] = wdata;
      if (sel_minstret) instret_d[31:0] = wdata;
      if (sel_minstreth) instret_d[63:32] = wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      cycle_q   <= '0;
      instret_q <= '0;
    end else begin
      cycle_q   <= cycle_d;
      instret_q <= instret_d;
    end
  end

  // tx byte, pulse follows the completing write
  always_ff @(posedge clk) begin
    if (rst) begin
      uart_tx_valid <= 1'b0;
      uart_q        <= '0;
    end else begin
      uart_tx_valid <= do_write & sel_muarttx;
      if (do_write && sel_muarttx) begin
        uart_q <= wdata[7:0];
      end
    end
  end

  assign uart_tx_data = uart_q;

endmodule

`default_nettype wire

//--- source/bfs_regs.sv
// BFS register bank as wishbone classic slave; zero-wait ack, offsets above 4 answer err
`timescale 1ns/1ps
`default_nettype none
`include "csr_cfg.svh"

module bfs_regs import csr_pkg::*; (
  input  wire            clk,
  input  wire            rst,
  input  wire wb_m2s_t   wb_in,
  input  wire            bfs_done,
  output wb_s2m_t        wb_out,
  output logic           bfs_start,
  output bfs_cfg_t       bfs_cfg
);

  logic  hit;
  logic  known;
  logic  wr;
  logic  go;
  logic  busy_q;
  xlen_t rdata;

  assign hit   = wb_in.cyc & wb_in.stb;
  assign known = (wb_in.adr <= `BFS_QSIZE);

  always_comb begin
    case (wb_in.adr)
      `BFS_STAT:  rdata = {31'd0, busy_q};
      `BFS_ROOT:  rdata = bfs_cfg.root;
      `BFS_TARG:  rdata = bfs_cfg.targ;
      `BFS_QBASE: rdata = bfs_cfg.qbase;
      `BFS_QSIZE: rdata = bfs_cfg.qsize;
      default:    rdata = '0;
    endcase
  end

  // answer in the same cycle
  always_comb begin
    wb_out.ack = hit & known;
    wb_out.err = hit & ~known;
    wb_out.dat = rdata;
  end

  assign wr = hit & wb_in.we & wb_out.ack;
  assign go = wr & (wb_in.adr == `BFS_STAT) & wb_in.dat[0];

  // start wins over a done in the same cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q    <= 1'b0;
      bfs_start <= 1'b0;
    end else begin
      bfs_start <= go;
      if (go) begin
        busy_q <= 1'b1;
      end else if (bfs_done) begin
        busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      bfs_cfg <= '0;
    end else if (wr) begin
      case (wb_in.adr)
        `BFS_ROOT:  bfs_cfg.root  <= wb_in.dat;
        `BFS_TARG:  bfs_cfg.targ  <= wb_in.dat;
        `BFS_QBASE: bfs_cfg.qbase <= wb_in.dat;
        `BFS_QSIZE: bfs_cfg.qsize <= wb_in.dat;
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- source/bfs_wb_bridge.sv
// single-beat wishbone classic master; slave must answer in the same cycle or the access fails
`timescale 1ns/1ps
`default_nettype none

module bfs_wb_bridge import csr_pkg::*; (
  input  wire            clk,
  input  wire            rst,
  input  wire            bfs_valid,
  input  wire bfs_req_t  bfs_req,
  input  wire wb_s2m_t   wb_in,
  output wb_m2s_t        wb_out,
  output logic           bfs_rsp_valid,
  output bfs_rsp_t       bfs_rsp
);

  // one bus cycle per request, only while it is valid
  always_comb begin
    wb_out.cyc = bfs_valid;
    wb_out.stb = bfs_valid;
    wb_out.we  = bfs_valid & bfs_req.wen;
    wb_out.adr = bfs_req.addr;
    wb_out.dat = bfs_req.wdata;
  end

  // no ack and no err leaves valid low
  always_ff @(posedge clk) begin
    if (rst) begin
      bfs_rsp_valid <= 1'b0;
    end else begin
      bfs_rsp_valid <= bfs_valid & (wb_in.ack | wb_in.err);
    end
  end

  always_ff @(posedge clk) begin
    if (bfs_valid) begin
      bfs_rsp.error <= wb_in.err;
      bfs_rsp.rdata <= wb_in.dat;
    end
  end

endmodule

`default_nettype wire

//--- source/csr_pkg.sv
// shared types for the CSR unit and BFS bank; RV32 only, struct layouts are MSB first
`default_nettype none

package csr_pkg;

  typedef logic [31:0] xlen_t;
  typedef logic [11:0] csr_addr_t;
  typedef logic [6:0]  robid_t;
  typedef logic [5:0]  preg_t;
  typedef logic [3:0]  bfs_off_t;

  typedef enum logic [1:0] {
    CSR_READ  = 2'd0,
    CSR_WRITE = 2'd1,
    CSR_SET   = 2'd2,
    CSR_CLEAR = 2'd3
  } csr_op_t;

  // instruction from rename
  typedef struct packed {
    csr_op_t   op;
    robid_t    robid;
    preg_t     rd;
    xlen_t     op1;
    csr_addr_t addr;
  } csr_req_t;

  // writeback result
  typedef struct packed {
    logic       error;
    logic [4:0] ecause;
    robid_t     robid;
    preg_t      rd;
    xlen_t      result;
  } csr_resp_t;

  typedef struct packed {
    logic     wen;
    bfs_off_t addr;
    xlen_t    wdata;
  } bfs_req_t;

  typedef struct packed {
    logic  error;
    xlen_t rdata;
  } bfs_rsp_t;

  // wishbone classic, master to slave
  typedef struct packed {
    logic     cyc;
    logic     stb;
    logic     we;
    bfs_off_t adr;
    xlen_t    dat;
  } wb_m2s_t;

  typedef struct packed {
    logic  ack;
    logic  err;
    xlen_t dat;
  } wb_s2m_t;

  typedef struct packed {
    xlen_t root;
    xlen_t targ;
    xlen_t qbase;
    xlen_t qsize;
  } bfs_cfg_t;

endpackage

`default_nettype wire

//--- source/csr_cfg.svh
// machine-mode CSR addresses and BFS bank offsets; BFS range is any 0x7Dx address
`ifndef CSR_CFG_SVH
`define CSR_CFG_SVH

// counters
`define CSR_MCYCLE     12'hB00
`define CSR_MCYCLEH    12'hB80
`define CSR_MINSTRET   12'hB02
`define CSR_MINSTRETH  12'hB82

// uart, read-only status and tx byte
`define CSR_MUARTSTAT  12'hFC0
`define CSR_MUARTTX    12'h7C0

// upper eight address bits of the accelerator window
`define CSR_BFS_BASE   8'h7D

`define CSR_ML2STAT    12'h7E0

// accelerator register offsets
`define BFS_STAT       4'h0
`define BFS_ROOT       4'h1
`define BFS_TARG       4'h2
`define BFS_QBASE      4'h3
`define BFS_QSIZE      4'h4

// tx empty and rx empty, transmitter never backs up
`define UART_STAT_IDLE 32'h0000_0005

`define ECAUSE_ILLEGAL 5'd2

`endif
